// ==== source/descriptor_pkg.sv ====
package descriptor_pkg;

        //////////////////////////////////////////////////
        // stream format

        localparam int word_w      = 9;         // bit 8 flags head and tail
        localparam int byte_w      = 8;
        localparam int ts_w        = 19;
        localparam int bufid_cnt_w = 9;         // free count and thresholds

        // frame class sits in the top bits of the head byte
        localparam int class_w = 3;

        localparam logic [class_w-1:0] class_rc  = 3'd3;
        localparam logic [class_w-1:0] class_ptp = 3'd4;
        localparam logic [class_w-1:0] class_be  = 3'd6;

        //////////////////////////////////////////////////
        // byte positions inside a frame

        localparam int byte_idx_w = 4;

        localparam logic [byte_idx_w-1:0] idx_sat = 4'd14;

        // ptp timestamp bytes in msb first order
        localparam logic [byte_idx_w-1:0] ts_hi_idx  = 4'd3;
        localparam logic [byte_idx_w-1:0] ts_mid_idx = 4'd4;
        localparam logic [byte_idx_w-1:0] ts_lo_idx  = 4'd5;

        localparam logic [byte_idx_w-1:0] eth_type_hi_idx = 4'd12;
        localparam logic [byte_idx_w-1:0] eth_type_lo_idx = 4'd13;

        //////////////////////////////////////////////////
        // descriptor

        localparam int desc_bytes = 6;
        localparam int desc_w     = desc_bytes * byte_w;   // 48
        localparam int eth_type_w = 16;

endpackage

// ==== source/frame_admission.sv ====
`timescale 1ns/10ps

module frame_admission (
        input  logic                                    clk_sys,
        input  logic                                    reset_n,

        input  logic [descriptor_pkg::word_w-1:0]       i_data,
        input  logic                                    i_data_wr,
        input  logic [descriptor_pkg::ts_w-1:0]         i_rec_ts,
        input  logic [descriptor_pkg::bufid_cnt_w-1:0]  i_free_bufid_cnt,
        input  logic [descriptor_pkg::bufid_cnt_w-1:0]  i_be_threshold,
        input  logic [descriptor_pkg::bufid_cnt_w-1:0]  i_rc_threshold,

        output logic [descriptor_pkg::word_w-1:0]       o_data,
        output logic                                    o_data_wr,
        output logic [descriptor_pkg::byte_idx_w-1:0]   o_byte_idx,
        output logic [descriptor_pkg::ts_w-1:0]         o_frame_ts,
        output logic                                    o_pkt_discard_pulse
);
        import descriptor_pkg::*;

        localparam logic [1:0] st_idle = 2'd0;
        localparam logic [1:0] st_pass = 2'd1;
        localparam logic [1:0] st_disc = 2'd2;

        logic [1:0]             state;
        logic                   head;           // also matches the tail word
        logic [class_w-1:0]     head_class;
        logic                   no_bufid;
        logic                   drop;

        assign head       = i_data_wr & i_data[word_w-1];
        assign head_class = i_data[byte_w-1 -: class_w];
        assign no_bufid   = (i_free_bufid_cnt == '0);

        //////////////////////////////////////////////////
        // admission rule per class

        always_comb begin
                case (head_class)
                class_rc: begin
                        drop = (i_free_bufid_cnt <= i_rc_threshold) || no_bufid;
                end
                class_be: begin
                        drop = (i_free_bufid_cnt <= i_rc_threshold) ||
                               (i_free_bufid_cnt <= i_be_threshold) || no_bufid;
                end
                default: begin
                        drop = no_bufid;
                end
                endcase
        end

        //////////////////////////////////////////////////
        // frame fsm

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        state               <= st_idle;
                        o_data              <= '0;
                        o_data_wr           <= 1'b0;
                        o_byte_idx          <= '0;
                        o_frame_ts          <= '0;
                        o_pkt_discard_pulse <= 1'b0;
                end else begin
                        o_data_wr           <= 1'b0;
                        o_pkt_discard_pulse <= 1'b0;
                        case (state)
                        st_idle: begin
                                if (head) begin
                                        if (drop) begin
                                                o_pkt_discard_pulse <= 1'b1;
                                                state               <= st_disc;
                                        end else begin
                                                o_data     <= i_data;
                                                o_data_wr  <= 1'b1;
                                                o_byte_idx <= '0;
                                                o_frame_ts <= i_rec_ts; // held for the frame
                                                state      <= st_pass;
                                        end
                                end
                        end
                        st_pass: begin
                                o_data    <= i_data;
                                o_data_wr <= i_data_wr;
                                if (i_data_wr && (o_byte_idx != idx_sat)) begin
                                        o_byte_idx <= o_byte_idx + 1'b1;
                                end
                                // tail, or strobe lost mid frame
                                if (!i_data_wr || i_data[word_w-1]) begin
                                        state <= st_idle;
                                end
                        end
                        st_disc: begin
                                if (head) begin         // tail of the dropped frame
                                        state <= st_idle;
                                end
                        end
                        default: begin
                                state <= st_idle;
                        end
                        endcase
                end
        end

endmodule

// ==== source/ptp_ts_insert.sv ====
`timescale 1ns/10ps

module ptp_ts_insert (
        input  logic                                    clk_sys,
        input  logic                                    reset_n,

        input  logic [descriptor_pkg::word_w-1:0]       i_data,
        input  logic                                    i_data_wr,
        input  logic [descriptor_pkg::byte_idx_w-1:0]   i_byte_idx,
        input  logic [descriptor_pkg::ts_w-1:0]         i_frame_ts,

        output logic [descriptor_pkg::word_w-1:0]       o_data,
        output logic                                    o_data_wr,
        output logic [descriptor_pkg::byte_idx_w-1:0]   o_byte_idx
);
        import descriptor_pkg::*;

        logic                   ptp_frame;      // class of the current frame
        logic                   at_head;
        logic [byte_w-1:0]      ins_byte;

        assign at_head = i_data_wr && (i_byte_idx == '0);

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        ptp_frame <= 1'b0;
                end else if (at_head) begin
                        ptp_frame <= (i_data[byte_w-1 -: class_w] == class_ptp);
                end
        end

        //////////////////////////////////////////////////
        // timestamp overlay on bytes 3 to 5

        always_comb begin
                ins_byte = i_data[byte_w-1:0];
                if (ptp_frame) begin
                        case (i_byte_idx)
                        ts_hi_idx: begin
                                // upper five bits of byte 3 are kept
                                ins_byte = {i_data[byte_w-1:3], i_frame_ts[ts_w-1:16]};
                        end
                        ts_mid_idx: begin
                                ins_byte = i_frame_ts[15:8];
                        end
                        ts_lo_idx: begin
                                ins_byte = i_frame_ts[7:0];
                        end
                        default: begin
                                ins_byte = i_data[byte_w-1:0];
                        end
                        endcase
                end
        end

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        o_data     <= '0;
                        o_data_wr  <= 1'b0;
                        o_byte_idx <= '0;
                end else begin
                        o_data     <= {i_data[word_w-1], ins_byte};     // flag bit untouched
                        o_data_wr  <= i_data_wr;
                        o_byte_idx <= i_byte_idx;
                end
        end

endmodule

// ==== source/descriptor_capture.sv ====
`timescale 1ns/10ps

module descriptor_capture (
        input  logic                                    clk_sys,
        input  logic                                    reset_n,

        input  logic [descriptor_pkg::word_w-1:0]       i_data,
        input  logic                                    i_data_wr,
        input  logic [descriptor_pkg::byte_idx_w-1:0]   i_byte_idx,

        output logic [descriptor_pkg::desc_w-1:0]       o_descriptor,
        output logic [descriptor_pkg::eth_type_w-1:0]   o_eth_type,
        output logic                                    o_descriptor_valid
);
        import descriptor_pkg::*;

        logic [desc_w-1:0]      desc_sr;        // byte 0 ends up on top
        logic [byte_w-1:0]      eth_hi;
        logic [byte_w-1:0]      cur_byte;
        logic                   in_desc;

        assign cur_byte = i_data[byte_w-1:0];
        assign in_desc  = (i_byte_idx < byte_idx_w'(desc_bytes));

        //////////////////////////////////////////////////
        // collect bytes 0 to 5 and the ethernet type high byte

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        desc_sr <= '0;
                        eth_hi  <= '0;
                end else if (i_data_wr) begin
                        if (in_desc) begin
                                desc_sr <= {desc_sr[desc_w-byte_w-1:0], cur_byte};
                        end
                        if (i_byte_idx == eth_type_hi_idx) begin
                                eth_hi <= cur_byte;
                        end
                end
        end

        //////////////////////////////////////////////////
        // publish at byte 13

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        o_descriptor       <= '0;
                        o_eth_type         <= '0;
                        o_descriptor_valid <= 1'b0;
                end else begin
                        o_descriptor_valid <= 1'b0;
                        if (i_data_wr && (i_byte_idx == eth_type_lo_idx)) begin
                                o_descriptor       <= desc_sr;
                                o_eth_type         <= {eth_hi, cur_byte};
                                o_descriptor_valid <= 1'b1;     // single cycle
                        end
                end
        end

endmodule

// ==== source/descriptor_extract.sv ====
`timescale 1ns/10ps

module descriptor_extract (
        input  logic                                    clk_sys,
        input  logic                                    reset_n,

        input  logic [descriptor_pkg::word_w-1:0]       i_data,
        input  logic                                    i_data_wr,
        input  logic [descriptor_pkg::ts_w-1:0]         i_rec_ts,
        input  logic [descriptor_pkg::bufid_cnt_w-1:0]  i_free_bufid_cnt,
        input  logic [descriptor_pkg::bufid_cnt_w-1:0]  i_be_threshold,
        input  logic [descriptor_pkg::bufid_cnt_w-1:0]  i_rc_threshold,

        output logic [descriptor_pkg::word_w-1:0]       o_data,
        output logic                                    o_data_wr,
        output logic                                    o_pkt_discard_pulse,
        output logic [descriptor_pkg::desc_w-1:0]       o_descriptor,
        output logic [descriptor_pkg::eth_type_w-1:0]   o_eth_type,
        output logic                                    o_descriptor_valid
);
        import descriptor_pkg::*;

        // admitted stream
        logic [word_w-1:0]      adm_data;
        logic                   adm_wr;
        logic [byte_idx_w-1:0]  adm_idx;
        logic [ts_w-1:0]        adm_ts;

        logic [byte_idx_w-1:0]  out_idx;        // adm_idx one cycle later

        //////////////////////////////////////////////////
        // stage 1 admits or drops frames

        frame_admission u_frame_admission (
                .clk_sys                (clk_sys),
                .reset_n                (reset_n),
                .i_data                 (i_data),
                .i_data_wr              (i_data_wr),
                .i_rec_ts               (i_rec_ts),
                .i_free_bufid_cnt       (i_free_bufid_cnt),
                .i_be_threshold         (i_be_threshold),
                .i_rc_threshold         (i_rc_threshold),
                .o_data                 (adm_data),
                .o_data_wr              (adm_wr),
                .o_byte_idx             (adm_idx),
                .o_frame_ts             (adm_ts),
                .o_pkt_discard_pulse    (o_pkt_discard_pulse)
        );

        //////////////////////////////////////////////////
        // stage 2 inserts the ptp timestamp

        ptp_ts_insert u_ptp_ts_insert (
                .clk_sys        (clk_sys),
                .reset_n        (reset_n),
                .i_data         (adm_data),
                .i_data_wr      (adm_wr),
                .i_byte_idx     (adm_idx),
                .i_frame_ts     (adm_ts),
                .o_data         (o_data),
                .o_data_wr      (o_data_wr),
                .o_byte_idx     (out_idx)
        );

        // taps the output stream
        descriptor_capture u_descriptor_capture (
                .clk_sys                (clk_sys),
                .reset_n                (reset_n),
                .i_data                 (o_data),
                .i_data_wr              (o_data_wr),
                .i_byte_idx             (out_idx),
                .o_descriptor           (o_descriptor),
                .o_eth_type             (o_eth_type),
                .o_descriptor_valid     (o_descriptor_valid)
        );

endmodule

// ==== include/tb_frame_table.svh ====
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// one row per frame with class, length, free count, rc and be thresholds, timestamp and discard
// classes other than rc (3), ptp (4) and be (6) only need a free buffer id

localparam int n_frames = 15;

function automatic frame_row_t frame_row(input int n);
        frame_row_t row;
        case (n)
        0:  row = '{3'd3, 16, 9'd20,  9'd10,  9'd30,  19'h00000, 1'b0};  // rc above threshold
        1:  row = '{3'd3, 16, 9'd10,  9'd10,  9'd30,  19'h00000, 1'b1};  // rc at threshold
        2:  row = '{3'd3, 14, 9'd0,   9'd0,   9'd0,   19'h00000, 1'b1};  // no buffer ids
        3:  row = '{3'd1, 20, 9'd5,   9'd10,  9'd30,  19'h00000, 1'b0};  // below both yet passes
        4:  row = '{3'd6, 16, 9'd30,  9'd10,  9'd30,  19'h00000, 1'b1};  // be at be threshold
        5:  row = '{3'd6, 16, 9'd8,   9'd10,  9'd4,   19'h00000, 1'b1};  // be under rc threshold
        6:  row = '{3'd6, 18, 9'd40,  9'd10,  9'd30,  19'h00000, 1'b0};
        7:  row = '{3'd4, 16, 9'd3,   9'd10,  9'd30,  19'h5a3c7, 1'b0};  // ptp
        8:  row = '{3'd1, 10, 9'd100, 9'd10,  9'd30,  19'h00000, 1'b0};  // too short for a descriptor
        9:  row = '{3'd4, 14, 9'd1,   9'd0,   9'd0,   19'h7ffff, 1'b0};
        10: row = '{3'd0, 15, 9'd0,   9'd10,  9'd30,  19'h00000, 1'b1};
        11: row = '{3'd7, 24, 9'd50,  9'd60,  9'd70,  19'h00000, 1'b0};  // index saturates
        12: row = '{3'd4, 8,  9'd9,   9'd10,  9'd30,  19'h12345, 1'b0};
        13: row = '{3'd3, 2,  9'd300, 9'd200, 9'd400, 19'h00000, 1'b0};  // head and tail only
        14: row = '{3'd2, 14, 9'd511, 9'd500, 9'd500, 19'h0abcd, 1'b0};
        default: row = '0;
        endcase
        return row;
endfunction

`endif

// ==== verif/tb_descriptor_extract.sv ====
`timescale 1ns/10ps

module tb_descriptor_extract;
        import descriptor_pkg::*;

        typedef struct packed {
                logic [class_w-1:0]     cls;
                int                     len;
                logic [bufid_cnt_w-1:0] free_cnt;
                logic [bufid_cnt_w-1:0] rc_thr;
                logic [bufid_cnt_w-1:0] be_thr;
                logic [ts_w-1:0]        ts;
                logic                   discard;
        } frame_row_t;

        `include "tb_frame_table.svh"

        localparam int reset_cycles  = 10;
        localparam int idle_gap      = 4;
        localparam int drain_timeout = 200;

        logic                   clk_sys = 1'b0;
        logic                   reset_n;
        logic [word_w-1:0]      i_data;
        logic                   i_data_wr;
        logic [ts_w-1:0]        i_rec_ts;
        logic [bufid_cnt_w-1:0] i_free_bufid_cnt;
        logic [bufid_cnt_w-1:0] i_be_threshold;
        logic [bufid_cnt_w-1:0] i_rc_threshold;
        logic [word_w-1:0]      o_data;
        logic                   o_data_wr;
        logic                   o_pkt_discard_pulse;
        logic [desc_w-1:0]      o_descriptor;
        logic [eth_type_w-1:0]  o_eth_type;
        logic                   o_descriptor_valid;

        int                     cycle = 0;      // rising edges so far
        logic [31:0]            lcg_state = 32'h094ee600;

        // expected responses with the cycle each one is due in
        logic [word_w-1:0]      exp_word_q[$];
        int                     exp_word_cyc_q[$];
        int                     exp_disc_cyc_q[$];
        logic [desc_w-1:0]      exp_desc_q[$];
        logic [eth_type_w-1:0]  exp_eth_q[$];
        int                     exp_desc_cyc_q[$];

        always #10 clk_sys = ~clk_sys;

        always @(posedge clk_sys) cycle <= cycle + 1;

        descriptor_extract i_dut (
                .clk_sys                (clk_sys),
                .reset_n                (reset_n),
                .i_data                 (i_data),
                .i_data_wr              (i_data_wr),
                .i_rec_ts               (i_rec_ts),
                .i_free_bufid_cnt       (i_free_bufid_cnt),
                .i_be_threshold         (i_be_threshold),
                .i_rc_threshold         (i_rc_threshold),
                .o_data                 (o_data),
                .o_data_wr              (o_data_wr),
                .o_pkt_discard_pulse    (o_pkt_discard_pulse),
                .o_descriptor           (o_descriptor),
                .o_eth_type             (o_eth_type),
                .o_descriptor_valid     (o_descriptor_valid)
        );

        //////////////////////////////////////////////////
        // error handling

        task automatic abort_run();
                $display("Test failed");
                $fatal(1, "simulation stopped on the first error");
        endtask

        task automatic fail_now(input string why);
                $display("%s at %0t ns", why, $time);
                abort_run();
        endtask

        task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
                if (actual !== expected) begin
                        $display("FAILED at %0t ns: %s, got %0h, expected %0h",
                                 $time, what, actual, expected);
                        abort_run();
                end
        endtask

        //////////////////////////////////////////////////
        // stimulus and reference model

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        // ptp frames carry the timestamp in bytes 3 to 5
        function automatic logic [word_w-1:0] expected_word(input frame_row_t row, input int idx,
                                                          input logic [word_w-1:0] word);
                logic [word_w-1:0] w;
                w = word;
                if (row.cls == class_ptp) begin
                        case (idx)
                        3: w[2:0] = row.ts[ts_w-1:16];
                        4: w[7:0] = row.ts[15:8];
                        5: w[7:0] = row.ts[7:0];
                        default: ;
                        endcase
                end
                return w;
        endfunction

        task automatic send_frame(input frame_row_t row);
                int                     i;
                int                     len;
                logic                   flag;
                logic [byte_w-1:0]      raw;
                logic [word_w-1:0]      word;
                logic [word_w-1:0]      out_word;
                logic [desc_w-1:0]      desc;
                logic [eth_type_w-1:0]  eth;
                len  = row.len;
                desc = '0;
                eth  = '0;
                i_free_bufid_cnt = row.free_cnt;        // held through the frame
                i_rc_threshold   = row.rc_thr;
                i_be_threshold   = row.be_thr;
                i_rec_ts         = row.ts;
                for (i = 0; i < len; i++) begin
                        lcg_state = lcg_next(lcg_state);
                        raw  = lcg_state[23:16];
                        flag = (i == 0) || (i == len - 1);
                        if (i == 0) begin
                                raw[byte_w-1 -: class_w] = row.cls;
                        end
                        word      = {flag, raw};
                        i_data    = word;
                        i_data_wr = 1'b1;
                        if (row.discard) begin
                                if (i == 0) begin
                                        exp_disc_cyc_q.push_back(cycle + 1);
                                end
                        end else begin
                                out_word = expected_word(row, i, word);
                                exp_word_q.push_back(out_word);
                                exp_word_cyc_q.push_back(cycle + 2);
                                if (i < desc_bytes) begin
                                        desc = {desc[desc_w-byte_w-1:0], out_word[byte_w-1:0]};
                                end
                                if (i == 12) begin
                                        eth[15:8] = out_word[byte_w-1:0];
                                end
                                if (i == 13) begin
                                        eth[7:0] = out_word[byte_w-1:0];
                                        exp_desc_q.push_back(desc);
                                        exp_eth_q.push_back(eth);
                                        exp_desc_cyc_q.push_back(cycle + 3);
                                end
                        end
                        @(negedge clk_sys);
                end
                i_data_wr = 1'b0;
                i_data    = '0;
                repeat (idle_gap) @(negedge clk_sys);
        endtask

        //////////////////////////////////////////////////
        // monitor sampled between rising edges

        always @(negedge clk_sys) begin
                if (reset_n) begin
                        if (o_data_wr) begin
                                if (exp_word_q.size() == 0) begin
                                        fail_now("output word with no admitted frame pending");
                                end else begin
                                        check(64'(cycle), 64'(exp_word_cyc_q.pop_front()),
                                              "output word cycle");
                                        check(64'(o_data), 64'(exp_word_q.pop_front()), "o_data");
                                end
                        end
                        if (o_pkt_discard_pulse) begin
                                if (exp_disc_cyc_q.size() == 0) begin
                                        fail_now("discard pulse with no discarded frame");
                                end else begin
                                        check(64'(cycle), 64'(exp_disc_cyc_q.pop_front()),
                                              "discard pulse cycle");
                                end
                        end
                        if (o_descriptor_valid) begin
                                if (exp_desc_q.size() == 0) begin
                                        fail_now("descriptor valid with no descriptor pending");
                                end else begin
                                        check(64'(cycle), 64'(exp_desc_cyc_q.pop_front()),
                                              "descriptor valid cycle");
                                        check(64'(o_descriptor), 64'(exp_desc_q.pop_front()),
                                              "o_descriptor");
                                        check(64'(o_eth_type), 64'(exp_eth_q.pop_front()),
                                              "o_eth_type");
                                end
                        end
                        // anything still queued for an earlier cycle never showed up
                        if (exp_word_cyc_q.size() != 0 && exp_word_cyc_q[0] < cycle) begin
                                fail_now("expected output word did not appear");
                        end
                        if (exp_disc_cyc_q.size() != 0 && exp_disc_cyc_q[0] < cycle) begin
                                fail_now("expected discard pulse did not appear");
                        end
                        if (exp_desc_cyc_q.size() != 0 && exp_desc_cyc_q[0] < cycle) begin
                                fail_now("expected descriptor valid did not appear");
                        end
                end
        end

        //////////////////////////////////////////////////
        // main sequence

        initial begin
                int n;
                int waited;
                reset_n          = 1'b0;
                i_data           = '0;
                i_data_wr        = 1'b0;
                i_rec_ts         = '0;
                i_free_bufid_cnt = '0;
                i_be_threshold   = '0;
                i_rc_threshold   = '0;
                repeat (reset_cycles) @(negedge clk_sys);
                reset_n = 1'b1;

                check(64'(o_data_wr), 64'(0), "o_data_wr after reset");
                check(64'(o_pkt_discard_pulse), 64'(0), "o_pkt_discard_pulse after reset");
                check(64'(o_descriptor_valid), 64'(0), "o_descriptor_valid after reset");
                check(64'(o_data), 64'(0), "o_data after reset");
                check(64'(o_descriptor), 64'(0), "o_descriptor after reset");
                check(64'(o_eth_type), 64'(0), "o_eth_type after reset");
                repeat (idle_gap) @(negedge clk_sys);   // strobes must stay low here

                for (n = 0; n < n_frames; n++) begin
                        send_frame(frame_row(n));
                end

                waited = 0;
                while ((exp_word_q.size() != 0 || exp_disc_cyc_q.size() != 0 ||
                        exp_desc_q.size() != 0) && waited < drain_timeout) begin
                        @(negedge clk_sys);
                        waited++;
                end

                if (exp_word_q.size() == 0 && exp_disc_cyc_q.size() == 0 &&
                    exp_desc_q.size() == 0) begin
                        repeat (idle_gap) @(negedge clk_sys);   // catch stray pulses
                        $display("Test passed");
                        $finish;
                end else begin
                        fail_now("timeout waiting for the expected outputs");
                end
        end

endmodule

// ==== vlog.f ====
+incdir+include
source/descriptor_pkg.sv
source/frame_admission.sv
source/ptp_ts_insert.sv
source/descriptor_capture.sv
source/descriptor_extract.sv
verif/tb_descriptor_extract.sv

// ==== Makefile ====
TOP := tb_descriptor_extract

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
